/* source/sram_ctrl_pkg.sv */
/* shared bus structs, step encoding and serial SRAM command bytes
   only byte mode commands are defined, page and sequential modes are not supported */
package sram_ctrl_pkg;

  // ==========================================================
  // bus structs
  // ==========================================================

  // AVR data memory register access from the host
  typedef struct packed {
    logic [7:0] adr;    // register address
    logic [7:0] wdata;  // write data
    logic       re;     // read enable
    logic       we;     // write enable
  } reg_bus_t;

  // request side of the SPI XB, same shape as the host bus
  typedef struct packed {
    logic [7:0] ramadr;   // SPI register address
    logic [7:0] dbus_in;  // data into the SPI block
    logic       ramre;    // read enable
    logic       ramwe;    // write enable
  } spi_bus_t;

  // control register, upper nibble reserved and reads as zero
  typedef struct packed {
    logic [3:0] rsvd;
    logic [2:0] spi_speed;    // ATmega328 SPR1:SPR0 plus SPI2X
    logic       ext_addr_en;  // 24 bit SRAM addressing
  } ctrl_reg_t;

  // one user access
  typedef struct packed {
    logic [23:0] addr;
    logic [7:0]  w_data;
    logic        write;   // 1 write, 0 read
  } mem_req_t;

  // ==========================================================
  // step encoding between sequencer and SPI XB engine
  // ==========================================================
  typedef enum logic [1:0] {
    STEP_SPCR,      // plain write of SPCR
    STEP_SPSR,      // plain write of SPSR
    STEP_SPI_BYTE   // full byte exchange through SPDR
  } step_kind_e;

  typedef struct packed {
    step_kind_e kind;
    logic [7:0] data;
  } xfer_step_t;

  localparam logic [7:0] SRAM_READ      = 8'h03;      // byte read command
  localparam logic [7:0] SRAM_WRITE     = 8'h02;      // byte write command
  localparam int         SPIF_BIT       = 7;          // transfer complete flag in SPSR
  localparam logic [5:0] SPCR_MASTER_EN = 6'b010100;  // SPE and MSTR set, mode 0, msb first
  localparam logic [7:0] SRAM_DUMMY     = 8'hFF;      // shifted out while read data comes in

endpackage

/* source/ctrl_reg_file.sv */
/* control register on the 8-bit register bus, readback is combinational
   any write, even of an unchanged value, requests a new SPI configuration */
`timescale 1ns/1ps

module ctrl_reg_file
#(
  parameter logic [7:0] MEMCR_ADDR = 8'hE0
)
(
  input  logic                     clk,
  input  logic                     rstn,
  input  sram_ctrl_pkg::reg_bus_t  reg_req,
  output logic [7:0]               dbus_out,
  output logic                     io_out_en,
  output sram_ctrl_pkg::ctrl_reg_t cfg,
  output logic                     cfg_pending,  // config sequence still owed
  input  logic                     cfg_taken     // sequencer started the config
);
  import sram_ctrl_pkg::*;

  // speed 100 (clk/2 with SPI2X), short addressing
  localparam ctrl_reg_t CFG_RESET = '{rsvd: 4'h0, spi_speed: 3'b100, ext_addr_en: 1'b0};

  logic memcr_hit;
  logic memcr_we;
  logic memcr_re;

  assign memcr_hit = (reg_req.adr == MEMCR_ADDR);
  assign memcr_we  = memcr_hit && reg_req.we;
  assign memcr_re  = memcr_hit && reg_req.re;

  assign dbus_out  = memcr_re ? cfg : 8'h00;  // zero when not selected so outputs can be ORed
  assign io_out_en = memcr_re;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      cfg         <= CFG_RESET;
      cfg_pending <= 1'b0;
    end
    else
    begin
      if (memcr_we)
      begin
        cfg <= '{rsvd: 4'h0, spi_speed: reg_req.wdata[3:1], ext_addr_en: reg_req.wdata[0]};
      end
      if (memcr_we)
        cfg_pending <= 1'b1;  // a write racing cfg_taken wins, config reruns
      else if (cfg_taken)
        cfg_pending <= 1'b0;
    end
  end

endmodule

/* source/sram_txn_seq.sv */
/* main FSM, config has priority over user requests while idle
   byte mode only, chip select is released after every single access */
`timescale 1ns/1ps

module sram_txn_seq
(
  input  logic                      clk,
  input  logic                      rstn,
  input  sram_ctrl_pkg::ctrl_reg_t  cfg,
  input  logic                      cfg_pending,
  output logic                      cfg_taken,
  input  logic                      req_valid,
  output logic                      req_ready,
  input  sram_ctrl_pkg::mem_req_t   req,
  output logic                      rsp_valid,
  output logic [7:0]                r_data,
  output logic                      cs_out,       // active low SRAM select
  output logic                      step_valid,
  input  logic                      step_ready,
  output sram_ctrl_pkg::xfer_step_t step,
  input  logic                      done,
  input  logic [7:0]                done_data
);
  import sram_ctrl_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_CFG_SPCR,
    S_CFG_SPSR,
    S_CMD,
    S_ADDR_HI,   // only with extended addressing
    S_ADDR_MID,
    S_ADDR_LO,
    S_DATA
  } seq_state_e;

  seq_state_e state;
  logic       ready_q;   // idle and able to take a request
  logic       issued;    // current step handed to the engine, waiting for done
  logic       step_fire;
  logic       req_fire;
  mem_req_t   req_q;     // request held for the whole transaction
  logic       ext_q;     // address width latched with the request

  assign cfg_taken = (state == S_IDLE) && cfg_pending;
  assign req_ready = ready_q && !cfg_pending;  // hold off users until config is done
  assign req_fire  = req_valid && req_ready;

  // one step per non idle state, dropped while the engine is busy with it
  assign step_valid = (state != S_IDLE) && !issued;
  assign step_fire  = step_valid && step_ready;

  // ==========================================================
  // step content per state
  // ==========================================================
  always_comb
  begin
    step.kind = STEP_SPI_BYTE;
    step.data = SRAM_DUMMY;
    case (state)
      S_CFG_SPCR:
      begin
        step.kind = STEP_SPCR;
        step.data = {SPCR_MASTER_EN, cfg.spi_speed[1:0]};  // master enable plus SPR1:SPR0
      end
      S_CFG_SPSR:
      begin
        step.kind = STEP_SPSR;
        step.data = {7'd0, cfg.spi_speed[2]};  // SPI2X
      end
      S_CMD:      step.data = req_q.write ? SRAM_WRITE : SRAM_READ;
      S_ADDR_HI:  step.data = req_q.addr[23:16];
      S_ADDR_MID: step.data = req_q.addr[15:8];
      S_ADDR_LO:  step.data = req_q.addr[7:0];
      S_DATA:     step.data = req_q.write ? req_q.w_data : SRAM_DUMMY;
      default:    step.data = SRAM_DUMMY;
    endcase
  end

  // request payload, captured on the handshake
  always_ff @(posedge clk)
  begin
    if (req_fire)
    begin
      req_q <= req;
      ext_q <= cfg.ext_addr_en;
    end
    if ((state == S_DATA) && done && !req_q.write)
      r_data <= done_data;  // byte clocked in during the dummy exchange
  end

  // ==========================================================
  // sequencer FSM
  // ==========================================================
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state     <= S_IDLE;
      ready_q   <= 1'b0;
      cs_out    <= 1'b1;   // inactive
      issued    <= 1'b0;
      rsp_valid <= 1'b0;
    end
    else
    begin
      rsp_valid <= 1'b0;   // single cycle pulse
      if (step_fire)
        issued <= 1'b1;
      else if (done)
        issued <= 1'b0;    // next step may go out the cycle after done

      case (state)
        S_IDLE:
        begin
          if (cfg_pending)
          begin
            ready_q <= 1'b0;
            state   <= S_CFG_SPCR;  // cs stays high through config
          end
          else if (req_fire)
          begin
            ready_q <= 1'b0;
            cs_out  <= 1'b0;        // select SRAM from the command byte on
            state   <= S_CMD;
          end
          else
            ready_q <= 1'b1;
        end
        S_CFG_SPCR: if (done) state <= S_CFG_SPSR;
        S_CFG_SPSR: if (done) state <= S_IDLE;
        S_CMD:      if (done) state <= ext_q ? S_ADDR_HI : S_ADDR_MID;
        S_ADDR_HI:  if (done) state <= S_ADDR_MID;
        S_ADDR_MID: if (done) state <= S_ADDR_LO;
        S_ADDR_LO:  if (done) state <= S_DATA;
        S_DATA:
        begin
          if (done)
          begin
            cs_out    <= 1'b1;           // end of transaction
            ready_q   <= 1'b1;
            rsp_valid <= !req_q.write;   // reads only
            state     <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

/* source/spi_xb_xfer.sv */
/* runs one step on the SPI XB, SPIF is polled with no timeout
   a byte exchange always ends with an SPDR read, which also clears SPIF */
`timescale 1ns/1ps

module spi_xb_xfer
#(
  parameter logic [7:0] SPCR_ADDR = 8'h4C,
  parameter logic [7:0] SPSR_ADDR = 8'h4D,
  parameter logic [7:0] SPDR_ADDR = 8'h4E
)
(
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      step_valid,
  output logic                      step_ready,
  input  sram_ctrl_pkg::xfer_step_t step,
  output logic                      done,       // one cycle, step finished
  output logic [7:0]                done_data,  // SPDR value of a byte exchange
  output sram_ctrl_pkg::spi_bus_t   spi_req,
  input  logic [7:0]                spi_dbus_out
);
  import sram_ctrl_pkg::*;

  typedef enum logic [1:0] {
    X_IDLE,
    X_WRITE,   // SPCR, SPSR or SPDR write
    X_POLL,    // read SPSR until SPIF
    X_READ     // drain SPDR
  } xfer_state_e;

  xfer_state_e state;
  xfer_step_t  step_q;
  logic [7:0]  wr_adr;

  assign step_ready = (state == X_IDLE);

  // step kind selects the target register
  always_comb
  begin
    case (step_q.kind)
      STEP_SPCR: wr_adr = SPCR_ADDR;
      STEP_SPSR: wr_adr = SPSR_ADDR;
      default:   wr_adr = SPDR_ADDR;
    endcase
  end

  // bus drive decoded from state, all enables low when idle
  always_comb
  begin
    spi_req = '0;
    case (state)
      X_WRITE:
      begin
        spi_req.ramwe   = 1'b1;
        spi_req.ramadr  = wr_adr;
        spi_req.dbus_in = step_q.data;
      end
      X_POLL:
      begin
        spi_req.ramre  = 1'b1;
        spi_req.ramadr = SPSR_ADDR;
      end
      X_READ:
      begin
        spi_req.ramre  = 1'b1;
        spi_req.ramadr = SPDR_ADDR;
      end
      default: spi_req = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (step_valid && step_ready)
      step_q <= step;
    if (state == X_READ)
      done_data <= spi_dbus_out;  // byte shifted in from the SRAM
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state <= X_IDLE;
      done  <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        X_IDLE:  if (step_valid) state <= X_WRITE;
        X_WRITE:
        begin
          if (step_q.kind == STEP_SPI_BYTE)
            state <= X_POLL;
          else
          begin
            done  <= 1'b1;   // register write only, no exchange
            state <= X_IDLE;
          end
        end
        X_POLL:  if (spi_dbus_out[SPIF_BIT]) state <= X_READ;
        X_READ:
        begin
          done  <= 1'b1;
          state <= X_IDLE;
        end
        default: state <= X_IDLE;
      endcase
    end
  end

endmodule

/* source/spi_sram_ctrl.sv */
/* serial SRAM controller in front of an SPI XB, the SPI block is always selected
   register addresses are parameters and must be distinct */
`timescale 1ns/1ps

module spi_sram_ctrl
#(
  parameter logic [7:0] MEMCR_ADDR = 8'hE0,  // control register
  parameter logic [7:0] SPCR_ADDR  = 8'h4C,  // SPI XB registers
  parameter logic [7:0] SPSR_ADDR  = 8'h4D,
  parameter logic [7:0] SPDR_ADDR  = 8'h4E
)
(
  input  logic                    clk,
  input  logic                    rstn,
  input  sram_ctrl_pkg::reg_bus_t reg_req,
  output logic [7:0]              dbus_out,
  output logic                    io_out_en,
  output sram_ctrl_pkg::spi_bus_t spi_req,
  input  logic [7:0]              spi_dbus_out,
  input  logic                    req_valid,
  output logic                    req_ready,
  input  sram_ctrl_pkg::mem_req_t req,
  output logic                    rsp_valid,
  output logic [7:0]              r_data,
  output logic                    cs_out
);
  import sram_ctrl_pkg::*;

  ctrl_reg_t  cfg;
  logic       cfg_pending;
  logic       cfg_taken;
  logic       step_valid;
  logic       step_ready;
  xfer_step_t step;
  logic       done;
  logic [7:0] done_data;

  ctrl_reg_file #(.MEMCR_ADDR(MEMCR_ADDR)) reg0 (
    .clk, .rstn, .reg_req, .dbus_out, .io_out_en, .cfg, .cfg_pending, .cfg_taken
  );

  sram_txn_seq seq0 (
    .clk, .rstn, .cfg, .cfg_pending, .cfg_taken, .req_valid, .req_ready, .req,
    .rsp_valid, .r_data, .cs_out, .step_valid, .step_ready, .step, .done, .done_data
  );

  spi_xb_xfer #(.SPCR_ADDR(SPCR_ADDR), .SPSR_ADDR(SPSR_ADDR), .SPDR_ADDR(SPDR_ADDR)) xfer0 (
    .clk, .rstn, .step_valid, .step_ready, .step, .done, .done_data, .spi_req, .spi_dbus_out
  );

endmodule

/* verif/spi_xb_sram_model.sv */
/* SPI XB register set with a byte mode serial SRAM behind it, SPIF after a random delay
   ext selects 24 bit addressing and must match the DUT control register */
`timescale 1ns/1ps

module spi_xb_sram_model
#(
  parameter logic [7:0] SPCR_ADDR = 8'h4C,
  parameter logic [7:0] SPSR_ADDR = 8'h4D,
  parameter logic [7:0] SPDR_ADDR = 8'h4E
)
(
  input  logic                    clk,
  input  logic                    rstn,
  input  sram_ctrl_pkg::spi_bus_t spi_req,
  output logic [7:0]              spi_dbus_out,
  input  logic                    cs_out,     // active low SRAM select
  input  logic                    ext,        // three address bytes
  output logic [7:0]              last_spcr,
  output logic [7:0]              last_spsr
);
  import sram_ctrl_pkg::*;

  logic [7:0]  spsr;
  logic [7:0]  spdr;
  logic [7:0]  cmd;                 // command byte of the running access
  logic [23:0] addr;                // address bytes shifted in msb first
  int          nb;                  // bytes exchanged since cs went low
  int          delay;               // cycles until SPIF
  logic [7:0]  mem [logic [23:0]];  // sparse SRAM, unwritten reads 0xFF

  // combinational readback
  always_comb
  begin
    spi_dbus_out = 8'h00;
    if (spi_req.ramre)
    begin
      if (spi_req.ramadr == SPSR_ADDR)      spi_dbus_out = spsr;
      else if (spi_req.ramadr == SPDR_ADDR) spi_dbus_out = spdr;
      else if (spi_req.ramadr == SPCR_ADDR) spi_dbus_out = last_spcr;
    end
  end

  always @(posedge clk or negedge rstn)
  begin : regs
    logic [23:0] full;
    full = ext ? addr : {8'h00, addr[15:0]};
    if (!rstn)
    begin
      spsr      <= 8'h00;
      spdr      <= 8'h00;
      last_spcr <= 8'h00;
      last_spsr <= 8'h00;
      nb        <= 0;
      delay     <= 0;
    end
    else
    begin
      if (cs_out) nb <= 0;  // deselect ends the access
      if (delay > 0)
      begin
        delay <= delay - 1;
        if (delay == 1) spsr[SPIF_BIT] <= 1'b1;  // byte shifted
      end
      if (spi_req.ramre && (spi_req.ramadr == SPDR_ADDR))
        spsr[SPIF_BIT] <= 1'b0;  // SPDR read clears SPIF
      if (spi_req.ramwe)
      begin
        if (spi_req.ramadr == SPCR_ADDR)
          last_spcr <= spi_req.dbus_in;
        else if (spi_req.ramadr == SPSR_ADDR)
        begin
          last_spsr <= spi_req.dbus_in;
          spsr[6:0] <= spi_req.dbus_in[6:0];
        end
        else if (spi_req.ramadr == SPDR_ADDR)
        begin
          delay <= 1 + ($urandom % 4);
          nb    <= nb + 1;
          if (nb == 0)
          begin
            cmd  <= spi_req.dbus_in;
            spdr <= 8'hFF;
          end
          else if (nb <= (ext ? 3 : 2))
          begin
            addr <= {addr[15:0], spi_req.dbus_in};
            spdr <= 8'hFF;
          end
          else
          begin
            if (cmd == SRAM_WRITE) mem[full] = spi_req.dbus_in;
            spdr <= mem.exists(full) ? mem[full] : 8'hFF;
          end
        end
      end
    end
  end

endmodule

/* verif/spi_sram_ctrl_props.sv */
/* protocol properties of the controller top level, bound into spi_sram_ctrl
   all checks are disabled while rstn is low */
`timescale 1ns/1ps

module spi_sram_ctrl_props
(
  input logic                    clk,
  input logic                    rstn,
  input logic                    req_ready,
  input logic                    rsp_valid,
  input logic                    cs_out,
  input sram_ctrl_pkg::spi_bus_t spi_req
);

  // SRAM never selected while idle
  idle_deselect: assert property (@(posedge clk) disable iff (!rstn) req_ready |-> cs_out)
    else $error("cs_out low while req_ready high");

  rsp_single: assert property (@(posedge clk) disable iff (!rstn) rsp_valid |=> !rsp_valid)
    else $error("rsp_valid longer than one cycle");

  bus_excl: assert property (@(posedge clk) disable iff (!rstn) !(spi_req.ramre && spi_req.ramwe))
    else $error("ramre and ramwe high together");

endmodule

/* verif/tb_spi_sram_ctrl.sv */
/* table driven testbench, each row is a config, write or read, checks stop at the first error
   read expectations come from a shadow memory built with the table */
`timescale 1ns/1ps

module tb_spi_sram_ctrl;
  import sram_ctrl_pkg::*;

  localparam logic [7:0] MEMCR = 8'hE0;
  localparam logic [7:0] SPCR  = 8'h4C;
  localparam logic [7:0] SPSR  = 8'h4D;
  localparam logic [7:0] SPDR  = 8'h4E;
  localparam int N_ROWS = 19;
  localparam int LIMIT  = 2000;  // cycles per wait

  typedef struct packed {
    logic [1:0]  op;    // 0 config, 1 write, 2 read
    logic [23:0] addr;
    logic [7:0]  data;
    logic [7:0]  exp;   // readback or read data
  } row_t;

  logic clk, rstn, req_valid, req_ready, rsp_valid, io_out_en, cs_out, ext_mode;
  logic [7:0] dbus_out, spi_dbus_out, r_data, last_spcr, last_spsr, exp_spcr, exp_spsr;
  reg_bus_t reg_req;
  spi_bus_t spi_req;
  mem_req_t req;
  row_t rows [N_ROWS];
  logic [7:0] shadow [logic [23:0]];
  int rsp_cnt, fire_cnt, n_reads, n_reqs;

  spi_sram_ctrl #(.MEMCR_ADDR(MEMCR), .SPCR_ADDR(SPCR), .SPSR_ADDR(SPSR), .SPDR_ADDR(SPDR)) dut0 (
    .clk, .rstn, .reg_req, .dbus_out, .io_out_en, .spi_req, .spi_dbus_out,
    .req_valid, .req_ready, .req, .rsp_valid, .r_data, .cs_out
  );
  spi_xb_sram_model #(.SPCR_ADDR(SPCR), .SPSR_ADDR(SPSR), .SPDR_ADDR(SPDR)) model0 (
    .clk, .rstn, .spi_req, .spi_dbus_out, .cs_out, .ext(ext_mode), .last_spcr, .last_spsr
  );
  bind spi_sram_ctrl spi_sram_ctrl_props props0 (
    .clk, .rstn, .req_ready, .rsp_valid, .cs_out, .spi_req
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // handshake monitors sampled mid cycle
  always @(negedge clk)
  begin
    if (rsp_valid) rsp_cnt++;
    if (req_valid && req_ready) fire_cnt++;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  // returns at posedge+2 after the transfer edge
  task automatic wait_accept();
    int n;
    for (n = 0; n < LIMIT; n++)
    begin
      @(negedge clk);
      if (req_ready) break;
    end
    if (n == LIMIT) report_timeout("req_ready");
    check("last_spcr", last_spcr, exp_spcr);  // config done before accept
    check("last_spsr", last_spsr, exp_spsr);
    @(posedge clk);
    #2 req_valid = 1'b0;
  endtask

  task automatic wait_rsp(input logic [7:0] exp);
    int n;
    for (n = 0; n < LIMIT; n++)
    begin
      @(negedge clk);
      if (rsp_valid) break;
    end
    if (n == LIMIT) report_timeout("rsp_valid");
    check("r_data", r_data, exp);
    @(posedge clk);
    #2;
  endtask

  task automatic write_memcr(input logic [7:0] val, input logic [7:0] rb);
    int n;
    for (n = 0; n < LIMIT; n++)
    begin
      @(negedge clk);
      if (req_ready) break;  // let the running access finish first
    end
    if (n == LIMIT) report_timeout("idle before config");
    @(posedge clk);
    #2 reg_req = '{adr: MEMCR, wdata: val, re: 1'b0, we: 1'b1};
    @(posedge clk);
    #2 reg_req = '{adr: MEMCR, wdata: 8'h00, re: 1'b1, we: 1'b0};
    ext_mode = val[0];
    exp_spcr = {SPCR_MASTER_EN, val[2:1]};
    exp_spsr = {7'd0, val[3]};
    @(negedge clk);
    check("dbus_out", dbus_out, rb);
    check("io_out_en", io_out_en, 1'b1);
    @(posedge clk);
    #2 reg_req = '0;
  endtask

  // ==========================================================
  // table and main sequence
  // ==========================================================
  initial
  begin : main
    logic ext_b;
    logic [23:0] key;
    void'($urandom(28));
    rstn      = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    reg_req   = '0;
    ext_mode  = 1'b0;
    exp_spcr  = 8'h00;  // model registers before any config
    exp_spsr  = 8'h00;
    rsp_cnt   = 0;
    fire_cnt  = 0;
    n_reads   = 0;
    n_reqs    = 0;
    rows[0] = '{op: 0, addr: 0, data: 8'hFB, exp: 8'h0B};
    rows[1] = '{op: 1, addr: 24'h123456, data: 8'($urandom), exp: 0};
    rows[2] = '{op: 1, addr: 24'h343456, data: 8'($urandom), exp: 0};
    rows[3] = '{op: 2, addr: 24'h123456, data: 0, exp: 0};
    rows[4] = '{op: 2, addr: 24'h343456, data: 0, exp: 0};
    rows[5] = '{op: 0, addr: 0, data: 8'h04, exp: 8'h04};  // speed 010, short addressing
    for (int i = 0; i < 6; i++)
    begin
      rows[6 + i]  = '{op: 1, addr: {9'd0, 15'($urandom)}, data: 8'($urandom), exp: 0};
      rows[12 + i] = '{op: 2, addr: rows[6 + i].addr, data: 0, exp: 0};
    end
    rows[18] = '{op: 2, addr: 24'h008001, data: 0, exp: 0};  // never written
    ext_b = 1'b0;
    for (int i = 0; i < N_ROWS; i++)
    begin
      key = ext_b ? rows[i].addr : {8'h00, rows[i].addr[15:0]};
      if (rows[i].op == 0) ext_b = rows[i].data[0];
      else if (rows[i].op == 1) shadow[key] = rows[i].data;
      else rows[i].exp = shadow.exists(key) ? shadow[key] : 8'hFF;
    end

    // reset state
    repeat (10)
    begin
      @(negedge clk);
      check("req_ready", req_ready, 1'b0);
      check("cs_out", cs_out, 1'b1);
      check("rsp_valid", rsp_valid, 1'b0);
      check("io_out_en", io_out_en, 1'b0);
      check("spi_req enables", {spi_req.ramre, spi_req.ramwe}, 2'b00);
    end
    @(posedge clk);
    #2 rstn = 1'b1;
    reg_req = '{adr: MEMCR, wdata: 8'h00, re: 1'b1, we: 1'b0};
    @(negedge clk);
    check("req_ready", req_ready, 1'b0);
    check("cs_out", cs_out, 1'b1);
    check("rsp_valid", rsp_valid, 1'b0);
    check("spi_req enables", {spi_req.ramre, spi_req.ramwe}, 2'b00);
    check("dbus_out", dbus_out, 8'h08);
    @(posedge clk);
    #2 reg_req = '0;

    for (int i = 0; i < N_ROWS; i++)
    begin
      if (rows[i].op == 0)
        write_memcr(rows[i].data, rows[i].exp);
      else
      begin
        req = '{addr: rows[i].addr, w_data: rows[i].data, write: rows[i].op == 1};
        req_valid = 1'b1;  // raised at once even while config runs
        n_reqs++;
        wait_accept();
        if (rows[i].op == 2)
        begin
          n_reads++;
          wait_rsp(rows[i].exp);
        end
      end
    end
    repeat (4) @(posedge clk);
    check("rsp count", rsp_cnt, n_reads);
    check("accept count", fire_cnt, n_reqs);
    $display("All tests passed!");
    $finish;
  end

endmodule

/* spi_sram_ctrl.f */
source/sram_ctrl_pkg.sv
source/ctrl_reg_file.sv
source/sram_txn_seq.sv
source/spi_xb_xfer.sv
source/spi_sram_ctrl.sv
verif/spi_xb_sram_model.sv
verif/spi_sram_ctrl_props.sv
verif/tb_spi_sram_ctrl.sv

/* Makefile */
TOP = tb_spi_sram_ctrl

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f spi_sram_ctrl.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
